//--- alu.sv
`timescale 1ns/1ps

module alu (
    input  core_pkg::alu_op_e           op,
    input  logic [rv_isa_pkg::XLEN-1:0] a,
    input  logic [rv_isa_pkg::XLEN-1:0] b,
    input  logic [2:0]                  branch_funct,
    output logic [rv_isa_pkg::XLEN-1:0] result,
    output logic                        branch_taken
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

    // decoder picks SUB for eq/ne and the compare ops for the rest.
    always_comb begin
        case (branch_funct)
            F3_BEQ:           branch_taken = (result == '0);
            F3_BNE:           branch_taken = (result != '0);
            F3_BLT, F3_BLTU:  branch_taken = result[0];
            F3_BGE, F3_BGEU:  branch_taken = ~result[0];
            default:          branch_taken = 1'b0;
        endcase
    end

endmodule

//--- core_pkg.sv
package core_pkg;

    localparam int NUM_REGS   = 32;
    localparam int LOAD_IDX_W = 16;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {ALU_REG, ALU_IMM, UPPER, STORE, BRANCH, ILLEGAL} instr_class_e;

    typedef enum logic [1:0] {LOAD, RUN, HALT} core_state_e;

    typedef enum logic [1:0] {REG_WRITE, MEM_STORE, BRANCH_DONE} commit_kind_e;

    typedef struct packed {
        logic [LOAD_IDX_W-1:0]        idx;  // word index into program memory.
        logic [rv_isa_pkg::XLEN-1:0]  word;
        logic                         last;
    } load_t;

    typedef struct packed {
        commit_kind_e                 kind;
        rv_isa_pkg::reg_addr_t        rd;
        logic [rv_isa_pkg::XLEN-1:0]  addr; // store address or next pc.
        logic [rv_isa_pkg::XLEN-1:0]  data;
    } commit_t;

    typedef struct packed {
        instr_class_e                 cls;
        alu_op_e                      alu_op;
        rv_isa_pkg::reg_addr_t        rs1;
        rv_isa_pkg::reg_addr_t        rs2;
        rv_isa_pkg::reg_addr_t        rd;
        logic [rv_isa_pkg::XLEN-1:0]  imm;
        logic [2:0]                   br_funct;
        logic                         b_is_imm;
    } decode_t;

endpackage

//--- files.f
rv_isa_pkg.sv
core_pkg.sv
instr_decoder.sv
reg_file.sv
alu.sv
instr_mem.sv
sc_core.sv
tb_commit_checker.sv
tb_sc_core.sv

//--- instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  logic [rv_isa_pkg::XLEN-1:0] instr,
    output core_pkg::decode_t           dec
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    instr_fields_t   f;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic            f7_base;
    logic            f7_alt;
    logic            is_shift;
    alu_op_e         f3_op;

    assign f = instr;

    assign f7_base  = (f.funct7 == FUNCT7_BASE);
    assign f7_alt   = (f.funct7 == FUNCT7_ALT);
    assign is_shift = (f.funct3 == F3_SLL) || (f.funct3 == F3_SRL_SRA);

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    // the alt marker picks SUB and SRA within the alu group.
    always_comb begin
        case (f.funct3)
            F3_ADD_SUB: f3_op = (f.opcode == OPC_OP && f7_alt) ? ALU_SUB : ALU_ADD;
            F3_SLL:     f3_op = ALU_SLL;
            F3_SLT:     f3_op = ALU_SLT;
            F3_SLTU:    f3_op = ALU_SLTU;
            F3_XOR:     f3_op = ALU_XOR;
            F3_SRL_SRA: f3_op = f7_alt ? ALU_SRA : ALU_SRL;
            F3_OR:      f3_op = ALU_OR;
            default:    f3_op = ALU_AND;
        endcase
    end

    always_comb begin
        dec.cls      = ILLEGAL;
        dec.alu_op   = f3_op;
        dec.rs1      = f.rs1;
        dec.rs2      = f.rs2;
        dec.rd       = f.rd;
        dec.imm      = imm_i;
        dec.br_funct = f.funct3;
        dec.b_is_imm = 1'b0;
        case (f.opcode)
            OPC_OP: begin
                if (f7_base || (f7_alt && (f.funct3 == F3_ADD_SUB || f.funct3 == F3_SRL_SRA))) begin
                    dec.cls = ALU_REG;
                end
            end
            OPC_OP_IMM: begin
                dec.b_is_imm = 1'b1;
                // shifts keep funct7 in the upper immediate bits.
                if (!is_shift || f7_base || (f7_alt && f.funct3 == F3_SRL_SRA)) begin
                    dec.cls = ALU_IMM;
                end
            end
            OPC_STORE: begin
                dec.alu_op   = ALU_ADD;     // address is rs1 + imm.
                dec.imm      = imm_s;
                dec.b_is_imm = 1'b1;
                if (f.funct3 == F3_SW) begin
                    dec.cls = STORE;
                end
            end
            OPC_BRANCH: begin
                dec.imm = imm_b;
                dec.cls = BRANCH;
                case (f.funct3)
                    F3_BEQ, F3_BNE:   dec.alu_op = ALU_SUB;
                    F3_BLT, F3_BGE:   dec.alu_op = ALU_SLT;
                    F3_BLTU, F3_BGEU: dec.alu_op = ALU_SLTU;
                    default:          dec.cls    = ILLEGAL;
                endcase
            end
            OPC_LUI: begin
                dec.cls    = UPPER;
                dec.alu_op = ALU_ADD;
                dec.imm    = imm_u;
            end
            default: ;
        endcase
    end

endmodule

//--- instr_mem.sv
`timescale 1ns/1ps

module instr_mem #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                             clk,
    input  logic                             wr_en,
    input  logic [core_pkg::LOAD_IDX_W-1:0]  wr_index,
    input  logic [rv_isa_pkg::XLEN-1:0]      wr_data,
    input  logic [rv_isa_pkg::XLEN-1:0]      fetch_addr,
    output logic [rv_isa_pkg::XLEN-1:0]      instr
);
    import core_pkg::*;

    localparam int AW = $clog2(IMEM_DEPTH);

    logic [rv_isa_pkg::XLEN-1:0] mem [IMEM_DEPTH];
    logic [AW-1:0]               fetch_idx;

    // word index wrapped to the memory depth.
    assign fetch_idx = AW'(fetch_addr[rv_isa_pkg::XLEN-1:2] % IMEM_DEPTH);
    assign instr     = mem[fetch_idx];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[AW'(wr_index)] <= wr_data;
        end
    end

    a_index_in_range: assert property (@(posedge clk)
        wr_en |-> {1'b0, wr_index} < (LOAD_IDX_W+1)'(IMEM_DEPTH));

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        we,
    input  rv_isa_pkg::reg_addr_t       waddr,
    input  logic [rv_isa_pkg::XLEN-1:0] wdata,
    input  rv_isa_pkg::reg_addr_t       raddr_a,
    output logic [rv_isa_pkg::XLEN-1:0] rdata_a,
    input  rv_isa_pkg::reg_addr_t       raddr_b,
    output logic [rv_isa_pkg::XLEN-1:0] rdata_b
);
    import core_pkg::*;

    logic [rv_isa_pkg::XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin  // x0 ignores writes.
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timescale 1ns/1ps -j 0 --top-module tb_sc_core \
    -f files.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "^ALL TESTS PASSED$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN = 32;

    typedef logic [4:0] reg_addr_t;

    // major opcodes handled by the core.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    // alu group shared by OP and OP_IMM.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // branch group.
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // only the word store is supported.
    localparam logic [2:0] F3_SW = 3'b010;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000; // bit 30 set for SUB and SRA.

    // R-type layout; the other formats reuse its fields.
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } instr_fields_t;

endpackage

//--- sc_core.sv
`timescale 1ns/1ps

module sc_core #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              load_valid,
    input  core_pkg::load_t   load,
    output logic              load_ready,
    output logic              commit_valid,
    output core_pkg::commit_t commit,
    input  logic              commit_ready,
    output logic              halted
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    core_state_e     state;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_next;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] br_target;
    logic [XLEN-1:0] instr;
    decode_t         dec;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] opb;
    logic [XLEN-1:0] alu_result;
    logic            br_taken;
    logic [XLEN-1:0] rf_wdata;
    logic            rf_we;
    logic            load_fire;
    logic            commit_fire;

    assign load_ready   = (state == LOAD);
    assign load_fire    = load_valid && load_ready;
    assign commit_valid = (state == RUN) && (dec.cls != ILLEGAL);
    assign commit_fire  = commit_valid && commit_ready;
    assign halted       = (state == HALT);

    instr_mem #(
        .IMEM_DEPTH(IMEM_DEPTH)
    ) u_imem (
        .clk       (clk),
        .wr_en     (load_fire),
        .wr_index  (load.idx),
        .wr_data   (load.word),
        .fetch_addr(pc),
        .instr     (instr)
    );

    instr_decoder u_dec (
        .instr(instr),
        .dec  (dec)
    );

    reg_file u_rf (
        .clk    (clk),
        .rst    (rst),
        .we     (rf_we),
        .waddr  (dec.rd),
        .wdata  (rf_wdata),
        .raddr_a(dec.rs1),
        .rdata_a(rs1_data),
        .raddr_b(dec.rs2),
        .rdata_b(rs2_data)
    );

    assign opb = dec.b_is_imm ? dec.imm : rs2_data;

    alu u_alu (
        .op          (dec.alu_op),
        .a           (rs1_data),
        .b           (opb),
        .branch_funct(dec.br_funct),
        .result      (alu_result),
        .branch_taken(br_taken)
    );

    assign pc_plus4  = pc + XLEN'(4);
    assign br_target = pc + dec.imm;
    assign pc_next   = (dec.cls == BRANCH && br_taken) ? br_target : pc_plus4;

    assign rf_wdata = (dec.cls == UPPER) ? dec.imm : alu_result;
    // registers change only when the commit is taken.
    assign rf_we    = commit_fire && (dec.cls == ALU_REG || dec.cls == ALU_IMM || dec.cls == UPPER);

    always_comb begin
        commit = '0;
        case (dec.cls)
            STORE: begin
                commit.kind = MEM_STORE;
                commit.addr = alu_result;
                commit.data = rs2_data;
            end
            BRANCH: begin
                commit.kind = BRANCH_DONE;
                commit.addr = pc_next;
            end
            default: begin
                commit.kind = REG_WRITE;
                commit.rd   = dec.rd;   // x0 is still reported.
                commit.data = rf_wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LOAD;
            pc    <= '0;
        end else begin
            case (state)
                LOAD: begin
                    if (load_fire && load.last) begin
                        state <= RUN;
                        pc    <= '0;
                    end
                end
                RUN: begin
                    if (dec.cls == ILLEGAL) begin
                        state <= HALT;
                    end else if (commit_fire) begin
                        pc <= pc_next;
                    end
                end
                default: ;  // halt holds until reset.
            endcase
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00);

    a_commit_stable: assert property (@(posedge clk) disable iff (rst)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit));

endmodule

//--- tb_commit_checker.sv
`timescale 1ns/1ps

module tb_commit_checker #(
    parameter int MAX_ROWS = 64
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              commit_valid,
    input  logic              commit_ready,
    input  core_pkg::commit_t commit,
    input  core_pkg::commit_t expected [MAX_ROWS],
    input  int                num_expected,
    output int                passed,
    output int                failed,
    output int                seen
);
    import core_pkg::*;

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want, inout bit ok);
        if (got !== want) begin
            $display("** Error at %0t: %s expected %h got %h", $time, name, want, got);
            ok = 1'b0;
        end
    endtask

    // one test per commit handshake in table order.
    always @(posedge clk) begin
        bit      ok;
        commit_t want;
        if (rst) begin
            passed <= 0;
            failed <= 0;
            seen   <= 0;
        end else if (commit_valid && commit_ready) begin
            ok   = 1'b1;
            want = '0;
            if (seen >= num_expected) begin
                $display("** Error at %0t: commit_valid expected 0 got 1", $time);
                ok = 1'b0;
            end else begin
                want = expected[seen];
                compare_field("commit.kind", 32'(commit.kind), 32'(want.kind), ok);
                case (want.kind)
                    REG_WRITE: begin
                        compare_field("commit.rd", 32'(commit.rd), 32'(want.rd), ok);
                        compare_field("commit.data", commit.data, want.data, ok);
                    end
                    MEM_STORE: begin
                        compare_field("commit.addr", commit.addr, want.addr, ok);
                        compare_field("commit.data", commit.data, want.data, ok);
                    end
                    default: compare_field("commit.addr", commit.addr, want.addr, ok);
                endcase
            end
            if (ok) begin
                $display("test commit %0d: kind %0d rd %0d addr %h data %h ok",
                         seen + 1, want.kind, want.rd, want.addr, want.data);
                passed <= passed + 1;
            end else begin
                $display("test commit %0d: mismatch", seen + 1);
                failed <= failed + 1;
            end
            seen <= seen + 1;
        end
    end

endmodule

//--- tb_sc_core.sv
`timescale 1ns/1ps

module tb_sc_core;
    import rv_isa_pkg::*;
    import core_pkg::*;

    localparam int IMEM_DEPTH  = 256;
    localparam int MAX_ROWS    = 64;
    localparam int WAIT_LIMIT  = 50;
    localparam int RUN_LIMIT   = 1000;
    localparam int HALT_WINDOW = 20;

    logic        clk;
    logic        rst;
    logic        load_valid;
    load_t       load;
    logic        load_ready;
    logic        commit_valid;
    commit_t     commit;
    logic        commit_ready;
    logic        halted;

    logic [31:0] prog [MAX_ROWS];
    commit_t     exp_commits [MAX_ROWS];
    int          num_words;
    int          num_commits;
    int          tb_tests;
    int          tb_errors;
    int          chk_passed;
    int          chk_failed;
    int          chk_seen;
    logic [31:0] rng_state;

    sc_core #(
        .IMEM_DEPTH(IMEM_DEPTH)
    ) UUT (
        .clk         (clk),
        .rst         (rst),
        .load_valid  (load_valid),
        .load        (load),
        .load_ready  (load_ready),
        .commit_valid(commit_valid),
        .commit      (commit),
        .commit_ready(commit_ready),
        .halted      (halted)
    );

    tb_commit_checker #(
        .MAX_ROWS(MAX_ROWS)
    ) u_checker (
        .clk         (clk),
        .rst         (rst),
        .commit_valid(commit_valid),
        .commit_ready(commit_ready),
        .commit      (commit),
        .expected    (exp_commits),
        .num_expected(num_commits),
        .passed      (chk_passed),
        .failed      (chk_failed),
        .seen        (chk_seen)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [2:0] f3, input int rd, input int rs1,
                                           input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] s_type(input int rs1, input int rs2, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], F3_SW, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input int rs1, input int rs2,
                                           input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], OPC_LUI};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic place_word(input logic [31:0] word);
        prog[num_words] = word;
        num_words++;
    endtask

    task automatic push_expected(input commit_kind_e kind, input int rd,
                                 input logic [31:0] addr, input logic [31:0] data);
        commit_t c;
        c      = '0;
        c.kind = kind;
        c.rd   = rd[4:0];
        c.addr = addr;
        c.data = data;
        exp_commits[num_commits] = c;
        num_commits++;
    endtask

    task automatic write_row(input logic [31:0] word, input int rd, input logic [31:0] data);
        place_word(word);
        push_expected(REG_WRITE, rd, 32'h0, data);
    endtask

    task automatic store_row(input logic [31:0] word, input logic [31:0] addr,
                             input logic [31:0] data);
        place_word(word);
        push_expected(MEM_STORE, 0, addr, data);
    endtask

    // a taken branch jumps over one word, which then must never commit.
    task automatic branch_case(input logic [2:0] f3, input int rs1, input int rs2,
                               input bit taken);
        logic [31:0] pc;
        pc = 32'(num_words) * 4;
        place_word(b_type(f3, rs1, rs2, 8));
        push_expected(BRANCH_DONE, 0, taken ? pc + 8 : pc + 4, 32'h0);
        if (taken) begin
            place_word(i_type(F3_ADD_SUB, 31, 0, 1));
        end
    endtask

    task automatic build_table();
        write_row(u_type(1, 'h80000), 1, 32'h80000000);
        write_row(i_type(F3_ADD_SUB, 2, 0, -5), 2, 32'hfffffffb);
        write_row(i_type(F3_ADD_SUB, 3, 0, 7), 3, 32'h00000007);
        write_row(u_type(4, 'h12345), 4, 32'h12345000);
        write_row(i_type(F3_ADD_SUB, 4, 4, 'h678), 4, 32'h12345678);
        write_row(r_type(FUNCT7_BASE, F3_ADD_SUB, 5, 2, 3), 5, 32'h00000002);
        write_row(r_type(FUNCT7_ALT, F3_ADD_SUB, 6, 3, 2), 6, 32'h0000000c);
        write_row(r_type(FUNCT7_BASE, F3_SLL, 7, 4, 3), 7, 32'h1a2b3c00);
        write_row(r_type(FUNCT7_BASE, F3_SLT, 8, 2, 3), 8, 32'h00000001);
        write_row(r_type(FUNCT7_BASE, F3_SLTU, 9, 2, 3), 9, 32'h00000000);
        write_row(r_type(FUNCT7_BASE, F3_XOR, 10, 4, 2), 10, 32'hedcba983);
        write_row(r_type(FUNCT7_BASE, F3_SRL_SRA, 11, 1, 3), 11, 32'h01000000);
        write_row(r_type(FUNCT7_ALT, F3_SRL_SRA, 12, 1, 3), 12, 32'hff000000);
        write_row(r_type(FUNCT7_BASE, F3_OR, 13, 4, 3), 13, 32'h1234567f);
        write_row(r_type(FUNCT7_BASE, F3_AND, 14, 2, 3), 14, 32'h00000003);
        write_row(i_type(F3_ADD_SUB, 15, 2, -100), 15, 32'hffffff97);
        write_row(i_type(F3_SLT, 16, 2, -4), 16, 32'h00000001);
        write_row(i_type(F3_SLTU, 17, 3, -1), 17, 32'h00000001);
        write_row(i_type(F3_XOR, 18, 4, -1), 18, 32'hedcba987);
        write_row(i_type(F3_OR, 19, 3, 'h700), 19, 32'h00000707);
        write_row(i_type(F3_AND, 20, 4, 'h0f0), 20, 32'h00000070);
        write_row(i_type(F3_SLL, 21, 3, 28), 21, 32'h70000000);
        write_row(i_type(F3_SRL_SRA, 22, 2, 4), 22, 32'h0fffffff);
        write_row(i_type(F3_SRL_SRA, 23, 2, 'h401), 23, 32'hfffffffd); // srai by 1.
        write_row(i_type(F3_ADD_SUB, 0, 3, 5), 0, 32'h0000000c);
        write_row(r_type(FUNCT7_BASE, F3_ADD_SUB, 24, 0, 4), 24, 32'h12345678);
        branch_case(F3_BEQ, 3, 3, 1'b1);
        branch_case(F3_BEQ, 3, 2, 1'b0);
        branch_case(F3_BNE, 2, 3, 1'b1);
        branch_case(F3_BNE, 3, 3, 1'b0);
        branch_case(F3_BLT, 2, 3, 1'b1);
        branch_case(F3_BLT, 3, 2, 1'b0);
        branch_case(F3_BGE, 3, 2, 1'b1);
        branch_case(F3_BGE, 2, 3, 1'b0);
        branch_case(F3_BLTU, 3, 2, 1'b1);
        branch_case(F3_BLTU, 2, 3, 1'b0);
        branch_case(F3_BGEU, 2, 3, 1'b1);
        branch_case(F3_BGEU, 3, 2, 1'b0);
        store_row(s_type(1, 4, 8), 32'h80000008, 32'h12345678);
        store_row(s_type(4, 2, -4), 32'h12345674, 32'hfffffffb);
        place_word(32'h00000000);                  // illegal word halts the core.
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        tb_tests++;
        if (got !== want) begin
            $display("** Error at %0t: %s expected %b got %b", $time, name, want, got);
            tb_errors++;
        end else begin
            $display("test %s: %b ok", name, got);
        end
    endtask

    task automatic report_timeout(input string msg);
        tb_tests++;
        tb_errors++;
        $display("%s", msg);
    endtask

    task automatic load_program(output bit ok);
        int waited;
        ok = 1'b1;
        for (int i = 0; i < num_words; i++) begin
            load_valid = 1'b1;
            load       = '{idx: 16'(i), word: prog[i], last: (i == num_words - 1)};
            waited     = 0;
            while (!load_ready && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (!load_ready) begin
                report_timeout($sformatf("timeout: load_ready stayed low for word %0d", i));
                ok = 1'b0;
                return;
            end
            @(posedge clk);                        // word taken on this edge.
            @(negedge clk);
        end
        load_valid = 1'b0;
    endtask

    initial begin
        int waited;
        bit loaded;
        bit saw_valid;
        int total_pass;
        int total_fail;
        rst          = 1'b1;
        load_valid   = 1'b0;
        load         = '0;
        commit_ready = 1'b0;
        rng_state    = 32'hae1c16e2;
        tb_tests     = 0;
        tb_errors    = 0;
        num_words    = 0;
        num_commits  = 0;
        build_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_bit("load_ready after reset", load_ready, 1'b1);
        check_bit("commit_valid after reset", commit_valid, 1'b0);
        check_bit("halted after reset", halted, 1'b0);

        load_program(loaded);
        if (loaded) begin
            check_bit("load_ready after last word", load_ready, 1'b0);
            waited = 0;
            while (!halted && waited < RUN_LIMIT) begin
                rng_state    = xorshift32(rng_state);
                commit_ready = (rng_state[1:0] != 2'b00); // ready about three cycles in four.
                @(negedge clk);
                waited++;
            end
            if (!halted) begin
                report_timeout($sformatf("timeout: core did not halt in %0d cycles", RUN_LIMIT));
            end else begin
                commit_ready = 1'b1;
                saw_valid    = 1'b0;
                repeat (HALT_WINDOW) begin
                    @(negedge clk);
                    saw_valid |= commit_valid;
                end
                check_bit("commit_valid after halt", saw_valid, 1'b0);
                check_bit("halted at end", halted, 1'b1);
                tb_tests++;
                if (chk_seen != num_commits) begin
                    $display("** Error at %0t: commit count expected %0d got %0d",
                             $time, num_commits, chk_seen);
                    tb_errors++;
                end else begin
                    $display("test commit count: %0d ok", chk_seen);
                end
            end
        end

        total_pass = (tb_tests - tb_errors) + chk_passed;
        total_fail = tb_errors + chk_failed;
        $display("summary: %0d tests, %0d passed, %0d failed",
                 total_pass + total_fail, total_pass, total_fail);
        if (total_fail == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
